// File: Makefile
VERILATOR ?= verilator
TOP       := tb_spi_flash_erase
RTL_TOP   := spi_flash_erase
FILELIST  := files.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+hw
hw/spi_link_pkg.sv
hw/flash_cmd_pkg.sv
hw/spi_byte_shifter.sv
hw/sector_erase_ctrl.sv
hw/spi_flash_erase.sv
testbench/spi_flash_model.sv
testbench/spi_flash_erase_assert.sv
testbench/tb_spi_flash_erase.sv

// File: hw/flash_cmd_pkg.sv
package flash_cmd_pkg;

    typedef logic [23:0] flash_addr_t;
    typedef logic [7:0]  flash_opcode_t;

    localparam flash_opcode_t OP_WREN = 8'h06; // Write enable
    localparam flash_opcode_t OP_SE   = 8'hD8; // Sector erase
    localparam flash_opcode_t OP_RDSR = 8'h05; // Read status register

    // Write in progress
    localparam int STATUS_WIP_BIT = 0;

    typedef enum logic [3:0] {
        IDLE,
        WREN_CMD,
        GAP1,
        SE_CMD,
        SE_ADDR,
        GAP2,
        RDSR_CMD,
        RDSR_DATA,
        POLL_GAP,
        DONE
    } erase_state_t;

endpackage

// File: hw/flash_settings.svh
`ifndef FLASH_SETTINGS_SVH
`define FLASH_SETTINGS_SVH

// sys_clk cycles per SCK half period
`define SCK_HALF_CYCLES 5

// Deselect time between frames, in sys_clk cycles
`define CS_GAP_CYCLES 8

// Must hold SCK_HALF_CYCLES - 1
`define SPI_HALF_CNT_W 4

`endif

// File: hw/sector_erase_ctrl.sv
`timescale 1ns/1ps
`include "flash_settings.svh"

module sector_erase_ctrl (
    input  logic                        sys_clk,
    input  logic                        sys_rst_n,
    input  logic                        erase_start,
    input  flash_cmd_pkg::flash_addr_t  erase_addr,
    output spi_link_pkg::spi_tx_req_t   tx_req,
    input  spi_link_pkg::spi_rx_rsp_t   rx_rsp,
    output logic                        spi_cs_n,
    output logic                        busy,
    output logic                        done
);

    localparam int GAP_W    = $clog2(`CS_GAP_CYCLES + 1);
    localparam int GAP_LAST = `CS_GAP_CYCLES - 1;

    flash_cmd_pkg::erase_state_t state;
    flash_cmd_pkg::flash_addr_t  addr_q;
    logic [1:0]                  byte_idx;  // Address byte within SE frame
    logic [GAP_W-1:0]            gap_cnt;
    logic                        gap_end;
    spi_link_pkg::spi_byte_t     addr_byte;
    logic                        wip;

    assign gap_end = (gap_cnt == GAP_LAST[GAP_W-1:0]);
    assign wip     = rx_rsp.rx_byte[flash_cmd_pkg::STATUS_WIP_BIT];

    always_comb begin
        case (byte_idx)
            2'd0:    addr_byte = addr_q[23:16];
            2'd1:    addr_byte = addr_q[15:8];
            default: addr_byte = addr_q[7:0];
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (state == flash_cmd_pkg::IDLE && erase_start) begin
            addr_q <= erase_addr;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= flash_cmd_pkg::IDLE;
            tx_req   <= '0;
            byte_idx <= '0;
            gap_cnt  <= '0;
            spi_cs_n <= 1'b1;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else begin
            tx_req.start <= 1'b0;
            done         <= 1'b0;
            case (state)
                flash_cmd_pkg::IDLE: begin
                    if (erase_start) begin
                        state          <= flash_cmd_pkg::WREN_CMD;
                        busy           <= 1'b1;
                        spi_cs_n       <= 1'b0;
                        tx_req.start   <= 1'b1;
                        tx_req.tx_byte <= flash_cmd_pkg::OP_WREN;
                    end
                end
                flash_cmd_pkg::WREN_CMD: begin
                    if (rx_rsp.byte_done) begin
                        state    <= flash_cmd_pkg::GAP1;
                        spi_cs_n <= 1'b1;   // WREN is a frame of its own
                        gap_cnt  <= '0;
                    end
                end
                flash_cmd_pkg::GAP1: begin
                    if (gap_end) begin
                        state          <= flash_cmd_pkg::SE_CMD;
                        spi_cs_n       <= 1'b0;
                        tx_req.start   <= 1'b1;
                        tx_req.tx_byte <= flash_cmd_pkg::OP_SE;
                        byte_idx       <= '0;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                flash_cmd_pkg::SE_CMD: begin
                    if (rx_rsp.byte_done) begin
                        state          <= flash_cmd_pkg::SE_ADDR;
                        tx_req.start   <= 1'b1;
                        tx_req.tx_byte <= addr_byte;
                        byte_idx       <= 2'd1;
                    end
                end
                flash_cmd_pkg::SE_ADDR: begin
                    if (rx_rsp.byte_done) begin
                        if (byte_idx == 2'd3) begin
                            state    <= flash_cmd_pkg::GAP2;
                            spi_cs_n <= 1'b1;
                            gap_cnt  <= '0;
                        end else begin
                            tx_req.start   <= 1'b1;
                            tx_req.tx_byte <= addr_byte;
                            byte_idx       <= byte_idx + 2'd1;
                        end
                    end
                end
                flash_cmd_pkg::GAP2, flash_cmd_pkg::POLL_GAP: begin
                    if (gap_end) begin
                        state          <= flash_cmd_pkg::RDSR_CMD;
                        spi_cs_n       <= 1'b0;
                        tx_req.start   <= 1'b1;
                        tx_req.tx_byte <= flash_cmd_pkg::OP_RDSR;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                flash_cmd_pkg::RDSR_CMD: begin
                    if (rx_rsp.byte_done) begin
                        state          <= flash_cmd_pkg::RDSR_DATA;
                        tx_req.start   <= 1'b1;
                        tx_req.tx_byte <= 8'h00; // Dummy while status shifts in
                    end
                end
                flash_cmd_pkg::RDSR_DATA: begin
                    if (rx_rsp.byte_done) begin
                        spi_cs_n <= 1'b1;
                        gap_cnt  <= '0;
                        state    <= wip ? flash_cmd_pkg::POLL_GAP : flash_cmd_pkg::DONE;
                    end
                end
                flash_cmd_pkg::DONE: begin
                    state <= flash_cmd_pkg::IDLE;
                    done  <= 1'b1;
                    busy  <= 1'b0;
                end
                default: state <= flash_cmd_pkg::IDLE;
            endcase
        end
    end

endmodule

// File: hw/spi_byte_shifter.sv
`timescale 1ns/1ps
`include "flash_settings.svh"

module spi_byte_shifter (
    input  logic                      sys_clk,
    input  logic                      sys_rst_n,
    input  spi_link_pkg::spi_tx_req_t tx_req,
    output spi_link_pkg::spi_rx_rsp_t rx_rsp,
    input  logic                      spi_miso,
    output logic                      spi_sck,
    output logic                      spi_mosi
);

    localparam int HALF_LAST = `SCK_HALF_CYCLES - 1;

    logic                       active;
    logic [`SPI_HALF_CNT_W-1:0] half_cnt;
    logic [2:0]                 bit_cnt;
    logic                       byte_done;
    logic                       half_end;
    logic                       load;
    spi_link_pkg::spi_byte_t    tx_shift;
    spi_link_pkg::spi_byte_t    rx_shift;

    assign load     = !active && tx_req.start;
    assign half_end = active && (half_cnt == HALF_LAST[`SPI_HALF_CNT_W-1:0]);

    // SCK generation, MOSI update on falling edges
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            active    <= 1'b0;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
            spi_sck   <= 1'b0;
            spi_mosi  <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (load) begin
                active   <= 1'b1;
                half_cnt <= '0;
                bit_cnt  <= '0;
                spi_mosi <= tx_req.tx_byte[7]; // MSB goes out first
            end else if (half_end) begin
                half_cnt <= '0;
                spi_sck  <= ~spi_sck;
                if (spi_sck) begin
                    // Falling edge
                    if (bit_cnt == 3'd7) begin
                        active    <= 1'b0;
                        byte_done <= 1'b1;
                    end else begin
                        bit_cnt  <= bit_cnt + 3'd1;
                        spi_mosi <= tx_shift[7];
                    end
                end
            end else if (active) begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // Data shift registers
    always_ff @(posedge sys_clk) begin
        if (load) begin
            tx_shift <= {tx_req.tx_byte[6:0], 1'b0};
        end else if (half_end && spi_sck) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end

        if (half_end && !spi_sck) begin
            rx_shift <= {rx_shift[6:0], spi_miso}; // Sample on rising edge
        end
    end

    assign rx_rsp.byte_done = byte_done;
    assign rx_rsp.rx_byte   = rx_shift;

endmodule

// File: hw/spi_flash_erase.sv
`timescale 1ns/1ps

module spi_flash_erase (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       erase_start,
    input  flash_cmd_pkg::flash_addr_t erase_addr,
    input  logic                       spi_miso,
    output logic                       spi_sck,
    output logic                       spi_mosi,
    output logic                       spi_cs_n,
    output logic                       busy,
    output logic                       done
);

    spi_link_pkg::spi_tx_req_t tx_req;
    spi_link_pkg::spi_rx_rsp_t rx_rsp;

    // Command sequencing and chip select
    sector_erase_ctrl u_ctrl (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .erase_start (erase_start),
        .erase_addr  (erase_addr),
        .tx_req      (tx_req),
        .rx_rsp      (rx_rsp),
        .spi_cs_n    (spi_cs_n),
        .busy        (busy),
        .done        (done)
    );

    // Bit-level SPI, mode 0
    spi_byte_shifter u_shifter (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tx_req    (tx_req),
        .rx_rsp    (rx_rsp),
        .spi_miso  (spi_miso),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi)
    );

endmodule

// File: hw/spi_link_pkg.sv
package spi_link_pkg;

    // One byte on the serial line
    typedef logic [7:0] spi_byte_t;

    // Sequencer to shifter
    typedef struct packed {
        logic      start;     // One-cycle pulse, only while shifter idle
        spi_byte_t tx_byte;
    } spi_tx_req_t;

    // Shifter to sequencer
    typedef struct packed {
        logic      byte_done; // One-cycle pulse per start
        spi_byte_t rx_byte;   // Valid with byte_done
    } spi_rx_rsp_t;

endpackage

// File: testbench/spi_flash_erase_assert.sv
`timescale 1ns/1ps

module spi_flash_erase_assert (
    input logic sys_clk,
    input logic sys_rst_n,
    input logic spi_sck,
    input logic spi_mosi,
    input logic spi_cs_n,
    input logic busy,
    input logic done
);

    // Mode 0 clock idles low outside a frame
    sck_low_deselected: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        spi_cs_n |-> !spi_sck) else $error("spi_sck high while spi_cs_n is high");

    done_single_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        done |=> !done) else $error("done lasted more than one cycle");

    done_after_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        done |-> $past(busy)) else $error("done without busy in the cycle before");

    // Covers the rising edge too, MOSI may only move while SCK is low
    mosi_stable_sck_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        spi_sck |-> $stable(spi_mosi))
        else $error("spi_mosi changed while spi_sck was high");

endmodule

bind spi_flash_erase spi_flash_erase_assert u_assert (.*);

// File: testbench/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
    input  logic spi_sck,
    input  logic spi_mosi,
    input  logic spi_cs_n,
    input  int   busy_polls,
    output logic spi_miso
);

    logic [7:0] frame_byte [0:255][0:7];
    int         frame_len [0:255];
    int         frame_cnt = 0;
    int         bit_cnt = 0;
    int         byte_cnt = 0;
    int         polls_left = 0;     // Status reads still answered as busy
    logic       cs_q = 1'b1;
    logic       sck_q = 1'b0;
    logic [7:0] shift_in = 8'h00;
    logic [7:0] status_q = 8'h00;

    assign spi_miso = status_q[7];

    always @(spi_sck or spi_cs_n) begin
        if (!spi_cs_n && cs_q) begin
            bit_cnt  = 0;
            byte_cnt = 0;
            status_q = 8'h00;
        end else if (spi_cs_n && !cs_q) begin
            frame_len[frame_cnt] = byte_cnt;
            // Erase starts when the SE frame is deselected
            if (byte_cnt == 4 && frame_byte[frame_cnt][0] == flash_cmd_pkg::OP_SE) begin
                polls_left = busy_polls;
            end
            frame_cnt++;
        end else if (!spi_cs_n && spi_sck && !sck_q) begin
            shift_in = {shift_in[6:0], spi_mosi};
            bit_cnt++;
            if (bit_cnt == 8) begin
                frame_byte[frame_cnt][byte_cnt] = shift_in;
                byte_cnt++;
                bit_cnt = 0;
            end
        end else if (!spi_cs_n && !spi_sck && sck_q) begin
            if (bit_cnt == 0 && byte_cnt == 1 &&
                frame_byte[frame_cnt][0] == flash_cmd_pkg::OP_RDSR) begin
                status_q = {7'd0, polls_left != 0};  // WIP in bit 0
                if (polls_left != 0) begin
                    polls_left--;
                end
            end else begin
                status_q = {status_q[6:0], 1'b0};
            end
        end
        cs_q  = spi_cs_n;
        sck_q = spi_sck;
    end

endmodule

// File: testbench/tb_spi_flash_erase.sv
`timescale 1ns/1ps
`include "flash_settings.svh"

module tb_spi_flash_erase;

    localparam int CLK_PERIOD = 40;
    // 400 cycles per unit of (6 + busy_polls), summed over every erase below
    localparam int MAX_CYCLES = 400 * (7 + 6 + 9 + 8 + 5 * 9) + 100;

    logic                       sys_clk;
    logic                       sys_rst_n;
    logic                       erase_start;
    flash_cmd_pkg::flash_addr_t erase_addr;
    logic                       spi_miso;
    logic                       spi_sck, spi_mosi, spi_cs_n, busy, done;
    int                         busy_polls;
    int                         cycle_cnt = 0;
    int                         done_cnt = 0;
    int                         gap_run = 0;
    logic [31:0]                lcg_state = 32'hf1e0_9463;

    spi_flash_erase UUT (.*);
    spi_flash_model flash (.*);

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Test failed");
            $fatal(1, "Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    always @(posedge sys_clk) begin
        if (done) begin
            done_cnt <= done_cnt + 1;
        end
        // Deselect time between frames of one erase
        if (!busy) begin
            gap_run <= 0;
        end else if (spi_cs_n) begin
            gap_run <= gap_run + 1;
        end else begin
            if (gap_run != 0) begin
                check_value("cs_n gap >= CS_GAP_CYCLES", 1, 32'(gap_run >= `CS_GAP_CYCLES));
            end
            gap_run <= 0;
        end
    end

    // One erase up to done, then the frames seen by the flash
    task automatic run_erase(input flash_cmd_pkg::flash_addr_t addr, input int polls,
                             input int inject_at);
        int first;
        int se;
        int f;
        int done_before;
        int cycles;
        busy_polls  = polls;
        first       = flash.frame_cnt;
        se          = first + 1;
        done_before = done_cnt;
        cycles      = 0;
        @(posedge sys_clk);
        erase_start <= 1'b1;
        erase_addr  <= addr;
        @(posedge sys_clk);
        erase_start <= 1'b0;
        @(posedge sys_clk);
        while (!done) begin
            check_value("busy", 1, 32'(busy));
            erase_start <= (cycles == inject_at);  // Extra start in mid erase
            erase_addr  <= ~addr;
            cycles++;
            @(posedge sys_clk);
        end
        check_value("busy", 0, 32'(busy));
        repeat (4) @(posedge sys_clk);
        check_value("done count", done_before + 1, done_cnt);
        check_value("busy", 0, 32'(busy));
        check_value("spi_cs_n", 1, 32'(spi_cs_n));
        check_value("frame count", polls + 3, flash.frame_cnt - first);
        check_value("WREN frame length", 1, flash.frame_len[first]);
        check_value("WREN opcode", 32'(flash_cmd_pkg::OP_WREN), 32'(flash.frame_byte[first][0]));
        check_value("SE frame length", 4, flash.frame_len[se]);
        check_value("SE opcode", 32'(flash_cmd_pkg::OP_SE), 32'(flash.frame_byte[se][0]));
        check_value("SE addr[23:16]", 32'(addr[23:16]), 32'(flash.frame_byte[se][1]));
        check_value("SE addr[15:8]", 32'(addr[15:8]), 32'(flash.frame_byte[se][2]));
        check_value("SE addr[7:0]", 32'(addr[7:0]), 32'(flash.frame_byte[se][3]));
        for (f = first + 2; f < first + polls + 3; f++) begin
            check_value("RDSR frame length", 2, flash.frame_len[f]);
            check_value("RDSR opcode", 32'(flash_cmd_pkg::OP_RDSR), 32'(flash.frame_byte[f][0]));
        end
    endtask

    task automatic test_reset_state();
        check_value("spi_cs_n", 1, 32'(spi_cs_n));
        check_value("spi_sck", 0, 32'(spi_sck));
        check_value("spi_mosi", 0, 32'(spi_mosi));
        check_value("busy", 0, 32'(busy));
        check_value("done", 0, 32'(done));
    endtask

    task automatic test_random_sectors();
        flash_cmd_pkg::flash_addr_t addr;
        int polls;
        repeat (5) begin
            lcg_state = lcg_next(lcg_state);
            addr      = lcg_state[31:8];
            lcg_state = lcg_next(lcg_state);
            polls     = int'(lcg_state[31:30]);
            run_erase(addr, polls, -1);
        end
    endtask

    initial begin
        sys_rst_n   = 1'b0;
        erase_start = 1'b0;
        erase_addr  = '0;
        busy_polls  = 0;
        repeat (10) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        @(posedge sys_clk);
        test_reset_state();
        run_erase(24'hA5_5A3C, 1, -1);  // Command order
        run_erase(24'h01_0000, 0, -1);  // Status polling
        run_erase(24'h3F_F000, 3, -1);
        run_erase(24'h7E_8100, 2, 150); // Ignored start
        test_random_sectors();
        $display("Test passed");
        $finish;
    end

endmodule
